// ==== design/busConsts.svh ====
// Bus master constants
// Widths, port acknowledge codes and transfer size codes
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

`define DATA_W      32
`define ADDR_W      32

// Port acknowledge, gives the width of the responding port
`define DSACK_8     2'b10
`define DSACK_16    2'b01
`define DSACK_32    2'b00
`define DSACK_WAIT  2'b11   // Not ready yet

// Transfer size, bytes still to move
`define SIZ_1       2'b01
`define SIZ_2       2'b10
`define SIZ_3       2'b11
`define SIZ_4       2'b00   // Full long word

`endif

// ==== design/busPkg.sv ====
// Bus master shared types
// Address, data, size and acknowledge vectors and the sequencer states
`include "busConsts.svh"

package busPkg;

    typedef logic [`ADDR_W-1:0] busAddrT;
    typedef logic [`DATA_W-1:0] busDataT;

    typedef logic [1:0] busSizeT;   // SIZ code
    typedef logic [1:0] busAckT;    // DSACK code
    typedef logic [1:0] byteOffT;   // Byte within a long word

    // Bus cycle sequencer
    typedef enum logic [1:0] {
        CS_IDLE,
        CS_ADDR,
        CS_WAIT,
        CS_DONE
    } cycleStateT;

endpackage

// ==== design/busSizer.sv ====
// Dynamic bus sizing table
// Bytes moved by the current bus cycle and the size left afterwards
`timescale 1ns/10ps
`include "busConsts.svh"

module busSizer
    import busPkg::*;
(
    input  busAddrT    curAddr,
    input  busSizeT    remSize,
    input  busAckT     busAck,
    output logic [2:0] bytesTaken,
    output busSizeT    nextSize,
    output logic       lastCycle
);

    byteOffT    offset;
    logic [2:0] remBytes;
    logic [2:0] room;       // Bytes left in the port window
    logic [2:0] leftOver;

    assign offset = curAddr[1:0];

    // SIZ codes 1 to 3 equal their byte count
    assign remBytes = (remSize == `SIZ_4) ? 3'd4 : {1'b0, remSize};

    always_comb begin
        case (busAck)
            `DSACK_32: begin
                room = 3'd4 - {1'b0, offset};
            end
            `DSACK_16: begin
                room = offset[0] ? 3'd1 : 3'd2;
            end
            `DSACK_8: begin
                room = 3'd1;
            end
            default: begin
                room = 3'd0;    // Wait state
            end
        endcase
    end

    assign bytesTaken = (remBytes < room) ? remBytes : room;
    assign leftOver   = remBytes - bytesTaken;

    // Four left over only while waiting, which wraps back to SIZ_4
    assign nextSize  = leftOver[1:0];
    assign lastCycle = (leftOver == 3'd0);

endmodule

// ==== design/laneSteer.sv ====
// Operand register and byte lane steering
// Merges read lanes into a right-justified operand, replicates write bytes
`timescale 1ns/10ps
`include "busConsts.svh"

module laneSteer
    import busPkg::*;
(
    input  logic    CLK,
    input  logic    in_RESET,
    input  logic    loadOperand,
    input  logic    captureLanes,
    input  logic    busWrite,
    input  busAddrT curAddr,
    input  busSizeT remSize,
    input  busAckT  busAck,
    input  busDataT reqData,
    input  busDataT busDataIn,
    output busDataT busDataOut,
    output busDataT operand
);

    byteOffT    offset;
    logic [2:0] remBytes;
    logic [1:0] portStart;  // Top-down lane of the first byte
    logic [2:0] portBytes;
    busDataT    mergedData;

    assign offset   = curAddr[1:0];
    assign remBytes = (remSize == `SIZ_4) ? 3'd4 : {1'b0, remSize};

    always_comb begin
        case (busAck)
            `DSACK_32: begin
                portStart = offset;
                portBytes = 3'd4;
            end
            `DSACK_16: begin
                portStart = {1'b0, offset[0]};
                portBytes = 3'd2;
            end
            default: begin
                portStart = 2'd0;   // Byte port on D31-D24
                portBytes = 3'd1;
            end
        endcase
    end

    // Lane k from the top holds the k-th remaining operand byte, MSB first
    always_comb begin
        int pos;
        int remCnt;
        remCnt     = int'(remBytes);
        mergedData = operand;
        for (int lane = 0; lane < 4; lane++) begin
            pos = lane - int'(portStart);
            if (pos >= 0 && lane < int'(portBytes) && pos < remCnt) begin
                mergedData[8*(remCnt-1-pos) +: 8] = busDataIn[`DATA_W-1-8*lane -: 8];
            end
        end
    end

    // Write lanes serve a 32, 16 or 8 bit port at once
    always_comb begin
        int remCnt;
        int wide;
        int narrow;
        int byteSel;
        remCnt = int'(remBytes);
        for (int lane = 0; lane < 4; lane++) begin
            wide   = lane - int'(offset);
            narrow = lane - int'(offset[0]);
            if (wide >= 0 && wide < remCnt) begin
                byteSel = remCnt - 1 - wide;
            end else if (lane < 2 && narrow >= 0 && narrow < remCnt) begin
                byteSel = remCnt - 1 - narrow;
            end else begin
                byteSel = remCnt - 1;   // Unused lane, MS byte as filler
            end
            busDataOut[`DATA_W-1-8*lane -: 8] = operand[8*byteSel +: 8];
        end
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            operand <= '0;
        end else if (loadOperand) begin
            operand <= busWrite ? reqData : '0;     // Reads start from zero
        end else if (captureLanes && !busWrite) begin
            operand <= mergedData;
        end
    end

endmodule

// ==== design/busCycleFsm.sv ====
// Bus cycle sequencer
// Accepts a request, runs one bus cycle per port acknowledge until done
`timescale 1ns/10ps
`include "busConsts.svh"

module busCycleFsm
    import busPkg::*;
(
    input  logic       CLK,
    input  logic       in_RESET,
    input  logic       reqValid,
    input  logic       reqWrite,
    input  busAddrT    reqAddr,
    input  busSizeT    reqSize,
    output logic       reqReady,
    output logic       respValid,
    input  busAckT     busAck,
    input  logic [2:0] bytesTaken,
    input  busSizeT    nextSize,
    input  logic       lastCycle,
    output busAddrT    curAddr,
    output busSizeT    remSize,
    output logic       busWrite,
    output logic       addrStrobe,
    output logic       loadOperand,
    output logic       captureLanes
);

    cycleStateT state;
    logic       writeReg;
    logic       ackDone;

    assign ackDone = (busAck != `DSACK_WAIT);

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state    <= CS_IDLE;
            writeReg <= 1'b0;
        end else begin
            case (state)
                CS_IDLE: begin
                    if (reqValid) begin
                        curAddr  <= reqAddr;
                        remSize  <= reqSize;
                        writeReg <= reqWrite;
                        state    <= CS_ADDR;
                    end
                end
                CS_ADDR: begin
                    state <= CS_WAIT;
                end
                CS_WAIT: begin
                    if (ackDone) begin
                        if (lastCycle) begin
                            state <= CS_DONE;
                        end else begin
                            curAddr <= curAddr + busAddrT'(bytesTaken);
                            remSize <= nextSize;
                            state   <= CS_ADDR;
                        end
                    end
                end
                CS_DONE: begin
                    state <= CS_IDLE;
                end
                default: begin
                    state <= CS_IDLE;
                end
            endcase
        end
    end

    assign reqReady   = (state == CS_IDLE);
    assign respValid  = (state == CS_DONE);
    assign addrStrobe = (state == CS_WAIT);

    assign loadOperand  = reqValid && reqReady;
    assign captureLanes = addrStrobe && ackDone;

    // Follows the requester while idle so the operand loads the right way
    assign busWrite = (state == CS_IDLE) ? reqWrite : writeReg;

endmodule

// ==== design/busInterface.sv ====
// 32-bit bus master with dynamic bus sizing
// Splits one request into bus cycles sized by the port acknowledge
`timescale 1ns/10ps
`include "busConsts.svh"

module busInterface
    import busPkg::*;
(
    input  logic    CLK,
    input  logic    in_RESET,
    input  logic    reqValid,
    input  logic    reqWrite,
    input  busAddrT reqAddr,
    input  busSizeT reqSize,
    input  busDataT reqData,
    output logic    reqReady,
    output logic    respValid,
    output busDataT respData,
    output busAddrT busAddr,
    output busSizeT busSiz,
    output logic    busRnW,
    output logic    addrStrobe,
    output busDataT busDataOut,
    input  busDataT busDataIn,
    input  busAckT  busAck
);

    busAddrT    curAddr;
    busSizeT    remSize;
    logic [2:0] bytesTaken;
    busSizeT    nextSize;
    logic       lastCycle;
    logic       busWrite;
    logic       loadOperand;
    logic       captureLanes;
    busDataT    operand;

    busSizer sizer0 (
        .curAddr(curAddr),
        .remSize(remSize),
        .busAck(busAck),
        .bytesTaken(bytesTaken),
        .nextSize(nextSize),
        .lastCycle(lastCycle)
    );

    laneSteer steer0 (
        .CLK(CLK),
        .in_RESET(in_RESET),
        .loadOperand(loadOperand),
        .captureLanes(captureLanes),
        .busWrite(busWrite),
        .curAddr(curAddr),
        .remSize(remSize),
        .busAck(busAck),
        .reqData(reqData),
        .busDataIn(busDataIn),
        .busDataOut(busDataOut),
        .operand(operand)
    );

    busCycleFsm fsm0 (
        .CLK(CLK),
        .in_RESET(in_RESET),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqSize(reqSize),
        .reqReady(reqReady),
        .respValid(respValid),
        .busAck(busAck),
        .bytesTaken(bytesTaken),
        .nextSize(nextSize),
        .lastCycle(lastCycle),
        .curAddr(curAddr),
        .remSize(remSize),
        .busWrite(busWrite),
        .addrStrobe(addrStrobe),
        .loadOperand(loadOperand),
        .captureLanes(captureLanes)
    );

    assign busAddr  = curAddr;
    assign busSiz   = remSize;
    assign busRnW   = ~busWrite;
    assign respData = operand;  // Right-justified on reads

endmodule

// ==== verification/busChecker.sv ====
// Bus master checker
// Predicts each bus cycle from the sizing rules and compares results
`timescale 1ns/10ps
`include "busConsts.svh"

module busChecker
    import busPkg::*;
(
    input  logic    CLK,
    input  logic    in_RESET,
    input  logic    reqValid,
    input  logic    reqWrite,
    input  busAddrT reqAddr,
    input  busSizeT reqSize,
    input  busDataT reqData,
    input  logic    reqReady,
    input  logic    respValid,
    input  busDataT respData,
    input  busAddrT busAddr,
    input  busSizeT busSiz,
    input  logic    busRnW,
    input  logic    addrStrobe,
    input  busDataT busDataOut,
    input  busAckT  busAck,
    input  busDataT expData,
    input  busDataT memData,
    output int      errCount,
    output int      respCount
);

    logic    inFlight = 1'b0;
    logic    rstSeen = 1'b0;
    logic    heldStrobe = 1'b0;    // Last cycle was a write wait state
    busDataT heldData;
    logic    curWrite;
    busAddrT curAddr;
    busDataT curData;
    int      remBytes;
    int      totBytes;

    function automatic int byteCount(input busSizeT s);
        return (s == `SIZ_4) ? 4 : int'(s);
    endfunction

    // Room left in the port's aligned window
    function automatic int windowRoom(input busAddrT a, input busAckT ack);
        if (ack == `DSACK_32) begin
            return 4 - int'(a[1:0]);
        end else if (ack == `DSACK_16) begin
            return a[0] ? 1 : 2;
        end
        return 1;
    endfunction

    // Lane from the top that carries address a
    function automatic int laneOf(input busAddrT a, input busAckT ack);
        if (ack == `DSACK_32) begin
            return int'(a[1:0]);
        end else if (ack == `DSACK_16) begin
            return int'(a[0]);
        end
        return 0;
    endfunction

    task automatic failValue(input string name, input busDataT got, input busDataT exp);
        $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        errCount++;
    endtask

    task automatic failText(input string msg);
        $display("Error: %s at %0t", msg, $time);
        errCount++;
    endtask

    always @(posedge CLK) begin
        int take;
        int lane;
        int pos;
        busDataT mask;
        if (!in_RESET) begin
            if (rstSeen) begin
                if (addrStrobe !== 1'b0) failText("addrStrobe is high during reset");
                if (respValid !== 1'b0) failText("respValid is high during reset");
                if (reqReady !== 1'b1) failText("reqReady is low during reset");
            end else begin
                errCount  = 0;
                respCount = 0;
            end
            rstSeen    = 1'b1;
            inFlight   = 1'b0;
            heldStrobe = 1'b0;
        end else begin
            if (inFlight && reqReady) failText("reqReady is high while a request is in flight");
            if (addrStrobe) begin
                if (!inFlight) failText("addrStrobe without an accepted request");
                if (busAddr !== curAddr) failValue("busAddr", busAddr, curAddr);
                if (busSiz !== busSizeT'(remBytes)) begin
                    failValue("busSiz", 32'(busSiz), 32'(busSizeT'(remBytes)));
                end
                if (busRnW !== !curWrite) failValue("busRnW", 32'(busRnW), 32'(!curWrite));
                if (heldStrobe && busDataOut !== heldData) begin
                    failValue("busDataOut", busDataOut, heldData);
                end
                if (busAck != `DSACK_WAIT && remBytes > 0) begin
                    take = windowRoom(curAddr, busAck);
                    if (remBytes < take) take = remBytes;
                    for (int i = 0; i < take; i++) begin
                        lane = laneOf(curAddr + busAddrT'(i), busAck);
                        pos  = remBytes - 1 - i;    // MS remaining byte goes first
                        if (curWrite) begin
                            if (busDataOut[31-8*lane -: 8] !== curData[8*pos +: 8]) begin
                                failValue("busDataOut", busDataOut, curData);
                            end
                        end
                    end
                    curAddr  = curAddr + busAddrT'(take);
                    remBytes = remBytes - take;
                end
            end
            if (respValid) begin
                if (!inFlight) begin
                    failText("respValid without an accepted request");
                end else begin
                    if (remBytes != 0) failText("response came before all operand bytes moved");
                    mask = (totBytes == 4) ? 32'hFFFF_FFFF : (32'h1 << (8*totBytes)) - 32'h1;
                    if (!curWrite && respData !== expData) begin
                        failValue("respData", respData, expData);
                    end
                    if (curWrite && memData !== (curData & mask)) begin
                        failValue("memData", memData, curData & mask);
                    end
                    respCount++;
                end
                inFlight = 1'b0;
            end
            if (reqValid && reqReady) begin
                inFlight = 1'b1;
                curWrite = reqWrite;
                curAddr  = reqAddr;
                curData  = reqData;
                remBytes = byteCount(reqSize);
                totBytes = remBytes;
            end
            heldStrobe = addrStrobe && curWrite && (busAck == `DSACK_WAIT);
            heldData   = busDataOut;
        end
    end

endmodule

// ==== verification/tbBusInterface.sv ====
// Bus master testbench
// Replays the request trace against a sized port memory model
`timescale 1ns/10ps
`include "busConsts.svh"

module tbBusInterface
    import busPkg::*;
();

    logic    CLK;
    logic    in_RESET;
    logic    reqValid;
    logic    reqWrite;
    busAddrT reqAddr;
    busSizeT reqSize;
    busDataT reqData;
    logic    reqReady;
    logic    respValid;
    busDataT respData;
    busAddrT busAddr;
    busSizeT busSiz;
    logic    busRnW;
    logic    addrStrobe;
    busDataT busDataOut;
    busDataT busDataIn;
    busAckT  busAck;
    busDataT expData;
    busDataT memData;   // Memory bytes at the operand address
    int      errCount;
    int      respCount;

    logic [31:0] trKind [0:63];
    logic [31:0] trAddr [0:63];
    logic [31:0] trSize [0:63];
    logic [31:0] trWdata [0:63];
    logic [31:0] trWidth [0:63];
    logic [31:0] trWaits [0:63];
    logic [31:0] trRdata [0:63];
    int          numLines = 0;

    logic [7:0] mem [0:255];    // Port memory, low address byte
    int curLine = 0;
    int lineSeq = 0;
    int seenSeq = 0;
    int waitCnt = 0;
    int cycleCount = 0;
    int cycleLimit = 100000;
    bit traceOk;

    busInterface dut0 (
        .CLK(CLK), .in_RESET(in_RESET),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
        .reqSize(reqSize), .reqData(reqData), .reqReady(reqReady),
        .respValid(respValid), .respData(respData),
        .busAddr(busAddr), .busSiz(busSiz), .busRnW(busRnW),
        .addrStrobe(addrStrobe), .busDataOut(busDataOut),
        .busDataIn(busDataIn), .busAck(busAck)
    );

    busChecker check0 (
        .CLK(CLK), .in_RESET(in_RESET),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
        .reqSize(reqSize), .reqData(reqData), .reqReady(reqReady),
        .respValid(respValid), .respData(respData),
        .busAddr(busAddr), .busSiz(busSiz), .busRnW(busRnW),
        .addrStrobe(addrStrobe), .busDataOut(busDataOut), .busAck(busAck),
        .expData(expData), .memData(memData),
        .errCount(errCount), .respCount(respCount)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic busAckT ackCode(input int width);
        if (width == 32) return `DSACK_32;
        if (width == 16) return `DSACK_16;
        return `DSACK_8;
    endfunction

    // Lanes driven by a port of the given width
    function automatic busDataT portLanes(input busAddrT addr, input int width);
        busDataT d;
        d = 32'hEEEE_EEEE;  // Undriven lanes
        if (width == 32) begin
            for (int k = 0; k < 4; k++) d[31-8*k -: 8] = mem[{addr[7:2], 2'(k)}];
        end else if (width == 16) begin
            for (int k = 0; k < 2; k++) d[31-8*k -: 8] = mem[{addr[7:1], 1'(k)}];
        end else begin
            d[31:24] = mem[addr[7:0]];
        end
        return d;
    endfunction

    // Port memory, one process owns it
    always @(negedge CLK) begin
        logic [7:0] a;
        int room;
        int take;
        int lane;
        if (!in_RESET) begin
            for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'hA5;
            busAck  = `DSACK_WAIT;
            waitCnt = 0;
            memData = '0;
        end else begin
            if (lineSeq != seenSeq) begin
                seenSeq = lineSeq;
                if (trKind[curLine] == 32'd0) begin
                    for (int i = 0; i < int'(trSize[curLine]); i++) begin
                        a = trAddr[curLine][7:0] + 8'(i);
                        mem[a] = trRdata[curLine][8*(int'(trSize[curLine])-1-i) +: 8];
                    end
                end
            end
            if (!addrStrobe) begin
                busAck  = `DSACK_WAIT;
                waitCnt = 0;
            end else if (waitCnt < int'(trWaits[curLine])) begin
                busAck  = `DSACK_WAIT;
                waitCnt = waitCnt + 1;
            end else begin
                busAck    = ackCode(int'(trWidth[curLine]));
                busDataIn = portLanes(busAddr, int'(trWidth[curLine]));
                if (!busRnW) begin
                    if (trWidth[curLine] == 32'd32) room = 4 - int'(busAddr[1:0]);
                    else if (trWidth[curLine] == 32'd16) room = busAddr[0] ? 1 : 2;
                    else room = 1;
                    take = (busSiz == `SIZ_4) ? 4 : int'(busSiz);
                    if (room < take) take = room;
                    for (int i = 0; i < take; i++) begin
                        a = busAddr[7:0] + 8'(i);
                        if (trWidth[curLine] == 32'd32) lane = int'(a[1:0]);
                        else if (trWidth[curLine] == 32'd16) lane = int'(a[0]);
                        else lane = 0;
                        mem[a] = busDataOut[31-8*lane -: 8];
                    end
                end
            end
            // Right-justified, MS byte at the lowest address
            memData = '0;
            for (int i = 0; i < int'(trSize[curLine]); i++) begin
                a = trAddr[curLine][7:0] + 8'(i);
                memData[8*(int'(trSize[curLine])-1-i) +: 8] = mem[a];
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles without finishing the trace", cycleCount);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic readTrace(output bit ok);
        int fd;
        int n;
        bit bad;
        string line;
        logic [31:0] k, a, s, wd, w, ws, rd;
        ok  = 1'b0;
        bad = 1'b0;
        fd  = $fopen("verification/busTrace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %d %d %h", k, a, s, wd, w, ws, rd);
                    if (n != 7 || numLines >= 64) begin
                        bad = 1'b1;
                    end else begin
                        trKind[numLines]  = k;
                        trAddr[numLines]  = a;
                        trSize[numLines]  = s;
                        trWdata[numLines] = wd;
                        trWidth[numLines] = w;
                        trWaits[numLines] = ws;
                        trRdata[numLines] = rd;
                        numLines++;
                    end
                end
            end
            $fclose(fd);
            ok = (numLines > 0) && !bad;
        end
    endtask

    task automatic runRequest(input int i);
        @(negedge CLK);
        curLine  = i;
        lineSeq  = lineSeq + 1;
        reqValid = 1'b1;
        reqWrite = trKind[i][0];
        reqAddr  = trAddr[i];
        reqSize  = trSize[i][1:0];     // Four bytes wraps to SIZ_4
        reqData  = trWdata[i];
        expData  = trRdata[i];
        do @(posedge CLK); while (!reqReady);
        @(negedge CLK);
        reqValid = 1'b0;
        do @(posedge CLK); while (!respValid);
    endtask

    initial begin
        in_RESET  = 1'b0;
        reqValid  = 1'b0;
        reqWrite  = 1'b0;
        reqAddr   = '0;
        reqSize   = '0;
        reqData   = '0;
        busDataIn = '0;
        busAck    = `DSACK_WAIT;
        expData   = '0;
        readTrace(traceOk);
        if (!traceOk) begin
            $display("Trace file is missing or has a malformed line");
            $display("TESTS FAILED");
            $finish;
        end else begin
            cycleLimit = 50;
            for (int i = 0; i < numLines; i++) begin
                cycleLimit = cycleLimit + 4 * (2 + int'(trWaits[i])) + 3;
            end
            repeat (16) @(negedge CLK);
            in_RESET = 1'b1;
            for (int i = 0; i < numLines; i++) runRequest(i);
            repeat (4) @(negedge CLK);
            $display("Errors: %0d, responses: %0d of %0d", errCount, respCount, numLines);
            if (errCount == 0 && respCount == numLines) begin
                $display("TESTS PASSED");
            end else begin
                if (respCount != numLines) $display("Not every request got a response");
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+design
design/busPkg.sv
design/busSizer.sv
design/laneSteer.sv
design/busCycleFsm.sv
design/busInterface.sv
verification/busChecker.sv
verification/tbBusInterface.sv

// ==== run.sh ====
#!/bin/sh
# Builds the bus master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tbBusInterface -f files.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation log has no result"
    exit 1
fi
exit 0

// ==== verification/busTrace.txt ====
# Columns: kind (0 read, 1 write), address, size in bytes, write data, port width, wait states, read data
# Read data is right-justified and is what the port memory holds at the operand address
0 00001000 4 00000000 32 0 11223344
0 00001001 1 00000000 32 0 000000a1
0 00001002 2 00000000 32 0 0000b1b2
0 00001003 2 00000000 32 0 0000c1c2
0 00001001 3 00000000 32 0 00d1d2d3
0 00001002 4 00000000 32 0 e1e2e3e4
0 00001003 4 00000000 32 0 f1f2f3f4
0 00002001 1 00000000 16 0 000000a5
0 00002000 2 00000000 16 0 0000b5b6
0 00002001 2 00000000 16 0 0000c5c6
0 00002003 3 00000000 16 0 00d5d6d7
0 00002001 4 00000000 16 0 e5e6e7e8
0 00002002 4 00000000 16 0 f5f6f7f8
0 00003000 1 00000000 8 0 0000009a
0 00003001 2 00000000 8 0 00009b9c
0 00003003 3 00000000 8 0 009d9e9f
0 00003002 4 00000000 8 0 a0a1a2a3
1 00004000 4 8899aabb 32 0 00000000
1 00004001 3 00ccddee 32 0 00000000
1 00004003 2 00001234 32 0 00000000
1 00004001 4 5566778a 16 0 00000000
1 00004002 3 00abcdef 16 0 00000000
1 00004003 1 0000005c 8 0 00000000
1 00004001 4 deadbeef 8 0 00000000
0 00005003 4 00000000 32 2 13579bdf
0 00005001 3 00000000 16 1 002468ac
0 00005002 2 00000000 8 3 0000fedc
1 00005001 4 0badcafe 16 2 00000000
1 00005000 4 c001d00d 32 3 00000000
0 00005000 4 00000000 32 1 76543210
